// ==== compile.f ====
rtl/x86_reg_pkg.sv
rtl/modrm_pkg.sv
rtl/effective_address_decode.sv
rtl/displacement_decode.sv
rtl/operand_width_decode.sv
rtl/decode_result_register.sv
rtl/modrm_decode_stage.sv
sim/tb_modrm_decode_stage.sv

// ==== rtl/decode_result_register.sv ====
/*
 * decode result register
 * captures every decoded field on in_valid and presents it one cycle later
 */
module decode_result_register (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_valid,
    input  logic                     next_segment_reg_used,
    input  x86_reg_pkg::sreg_index_e next_segment_reg_index,
    input  logic                     next_base_reg_used,
    input  x86_reg_pkg::gpr_index_e  next_base_reg_index,
    input  logic                     next_index_reg_used,
    input  x86_reg_pkg::gpr_index_e  next_index_reg_index,
    input  logic                     next_sib_is_present,
    input  logic                     next_displacement_is_present,
    input  modrm_pkg::disp_len_t     next_displacement_length,
    input  logic                     next_gpr_reg_used,
    input  x86_reg_pkg::gpr_index_e  next_gpr_reg_index,
    input  x86_reg_pkg::gpr_width_e  next_gpr_reg_bit_width,
    output logic                     out_valid,
    output logic                     segment_reg_used,
    output x86_reg_pkg::sreg_index_e segment_reg_index,
    output logic                     base_reg_used,
    output x86_reg_pkg::gpr_index_e  base_reg_index,
    output logic                     index_reg_used,
    output x86_reg_pkg::gpr_index_e  index_reg_index,
    output logic                     sib_is_present,
    output logic                     displacement_is_present,
    output modrm_pkg::disp_len_t     displacement_length,
    output logic                     gpr_reg_used,
    output x86_reg_pkg::gpr_index_e  gpr_reg_index,
    output x86_reg_pkg::gpr_width_e  gpr_reg_bit_width
);

    // valid strobe follows the input by one cycle, no hold
    always_ff @(posedge clk) begin
        if (reset)
            out_valid <= 1'b0;
        else
            out_valid <= in_valid;
    end

    // fields hold their last value between strobes
    always_ff @(posedge clk) begin
        if (reset) begin
            segment_reg_used        <= 1'b0;
            segment_reg_index       <= x86_reg_pkg::ES;
            base_reg_used           <= 1'b0;
            base_reg_index          <= x86_reg_pkg::EAX;
            index_reg_used          <= 1'b0;
            index_reg_index         <= x86_reg_pkg::EAX;
            sib_is_present          <= 1'b0;
            displacement_is_present <= 1'b0;
            displacement_length     <= modrm_pkg::DISP_NONE;
            gpr_reg_used            <= 1'b0;
            gpr_reg_index           <= x86_reg_pkg::EAX;
            gpr_reg_bit_width       <= x86_reg_pkg::WIDTH_NONE;
        end else if (in_valid) begin
            segment_reg_used        <= next_segment_reg_used;
            segment_reg_index       <= next_segment_reg_index;
            base_reg_used           <= next_base_reg_used;
            base_reg_index          <= next_base_reg_index;
            index_reg_used          <= next_index_reg_used;
            index_reg_index         <= next_index_reg_index;
            sib_is_present          <= next_sib_is_present;
            displacement_is_present <= next_displacement_is_present;
            displacement_length     <= next_displacement_length;
            gpr_reg_used            <= next_gpr_reg_used;
            gpr_reg_index           <= next_gpr_reg_index;
            gpr_reg_bit_width       <= next_gpr_reg_bit_width;
        end
    end

    // a strobe during reset must not leak out afterwards
    assert property (@(posedge clk) reset |=> !out_valid)
        else $error("out_valid high in the cycle after reset");

endmodule

// ==== rtl/displacement_decode.sv ====
/*
 * displacement decode
 * number of displacement bytes that follow the mod r/m byte
 */
module displacement_decode (
    input  modrm_pkg::mod_e      mod,
    input  logic [2:0]           rm,
    input  modrm_pkg::op_size_e  default_operand_size,
    output logic                 displacement_is_present,
    output modrm_pkg::disp_len_t displacement_length
);

    logic size_is_16;

    assign size_is_16 = (default_operand_size == modrm_pkg::SIZE_16);

    always_comb begin
        displacement_length = modrm_pkg::DISP_NONE;
        case (mod)
            modrm_pkg::MOD_NO_DISP: begin
                // only the displacement-only rm code carries a full disp
                if (size_is_16 && rm == modrm_pkg::RM_DISP_ONLY_16)
                    displacement_length = modrm_pkg::DISP_WORD;
                else if (!size_is_16 && rm == modrm_pkg::RM_DISP_ONLY_32)
                    displacement_length = modrm_pkg::DISP_DWORD;
            end
            modrm_pkg::MOD_DISP8:
                displacement_length = modrm_pkg::DISP_BYTE;
            modrm_pkg::MOD_DISP_FULL:
                // full width follows the address size
                displacement_length = size_is_16 ? modrm_pkg::DISP_WORD
                                                 : modrm_pkg::DISP_DWORD;
            default:
                displacement_length = modrm_pkg::DISP_NONE;
        endcase
    end

    assign displacement_is_present = (displacement_length != modrm_pkg::DISP_NONE);

    // downstream fetch only knows how to consume these lengths
    always_comb begin
        if (!$isunknown({mod, rm, default_operand_size}))
            assert final (displacement_length inside {3'd0, 3'd1, 3'd2, 3'd4})
                else $error("illegal displacement length %0d", displacement_length);
    end

endmodule

// ==== rtl/effective_address_decode.sv ====
/*
 * effective address decode
 * maps mod, rm and the address size to the implied segment, the base
 * and index registers and whether an s-i-b byte follows
 */
module effective_address_decode (
    input  modrm_pkg::mod_e          mod,
    input  logic [2:0]               rm,
    input  modrm_pkg::op_size_e      default_operand_size,
    output logic                     segment_reg_used,
    output x86_reg_pkg::sreg_index_e segment_reg_index,
    output logic                     base_reg_used,
    output x86_reg_pkg::gpr_index_e  base_reg_index,
    output logic                     index_reg_used,
    output x86_reg_pkg::gpr_index_e  index_reg_index,
    output logic                     sib_is_present
);

    always_comb begin
        // register direct and sib cases leave everything unused and zero
        segment_reg_used  = 1'b0;
        segment_reg_index = x86_reg_pkg::ES;
        base_reg_used     = 1'b0;
        base_reg_index    = x86_reg_pkg::EAX;
        index_reg_used    = 1'b0;
        index_reg_index   = x86_reg_pkg::EAX;
        sib_is_present    = 1'b0;

        if (mod != modrm_pkg::MOD_REGISTER) begin
            if (default_operand_size == modrm_pkg::SIZE_16) begin
                // 16 bit table, every memory form has a segment
                segment_reg_used = 1'b1;
                // rm 0..3 are base + index pairs
                if (rm[2] == 1'b0) begin
                    base_reg_used   = 1'b1;
                    base_reg_index  = rm[1] ? x86_reg_pkg::BP : x86_reg_pkg::BX;
                    index_reg_used  = 1'b1;
                    index_reg_index = rm[0] ? x86_reg_pkg::DI : x86_reg_pkg::SI;
                end else if (rm[1] == 1'b0) begin
                    // rm 4, 5 index alone
                    index_reg_used  = 1'b1;
                    index_reg_index = rm[0] ? x86_reg_pkg::DI : x86_reg_pkg::SI;
                end else if (rm == modrm_pkg::RM_DISP_ONLY_16) begin
                    // [bp+disp], or a bare disp16 in mod 00
                    if (mod != modrm_pkg::MOD_NO_DISP) begin
                        base_reg_used  = 1'b1;
                        base_reg_index = x86_reg_pkg::BP;
                    end
                end else begin
                    // rm 7 is [bx]
                    base_reg_used  = 1'b1;
                    base_reg_index = x86_reg_pkg::BX;
                end
            end else if (rm == modrm_pkg::RM_SIB) begin
                // segment, base and index come from the sib byte
                sib_is_present = 1'b1;
            end else begin
                segment_reg_used = 1'b1;
                // mod 00 rm 101 is a bare disp32, no base at all
                if (!(rm == modrm_pkg::RM_DISP_ONLY_32 &&
                      mod == modrm_pkg::MOD_NO_DISP)) begin
                    base_reg_used  = 1'b1;
                    base_reg_index = x86_reg_pkg::gpr_index_e'(rm);
                end
            end

            // stack segment whenever the frame pointer is the base
            if (segment_reg_used) begin
                if (base_reg_used && base_reg_index == x86_reg_pkg::EBP)
                    segment_reg_index = x86_reg_pkg::SS;
                else
                    segment_reg_index = x86_reg_pkg::DS;
            end
        end
    end

    // the sib byte owns the base, so both can never be claimed here
    always_comb begin
        if (!$isunknown({mod, rm, default_operand_size}))
            assert final (!(sib_is_present && base_reg_used))
                else $error("sib_is_present together with base_reg_used");
    end

endmodule

// ==== rtl/modrm_decode_stage.sv ====
/*
 * mod r/m decode stage
 * splits the mod r/m byte, runs the three field decoders in parallel
 * and registers their results with a one cycle latency
 */
module modrm_decode_stage (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_valid,
    input  logic [7:0]               modrm,
    input  logic                     w_is_present,
    input  logic                     w,
    input  modrm_pkg::op_size_e      default_operand_size,
    output logic                     out_valid,
    output logic                     segment_reg_used,
    output x86_reg_pkg::sreg_index_e segment_reg_index,
    output logic                     base_reg_used,
    output x86_reg_pkg::gpr_index_e  base_reg_index,
    output logic                     index_reg_used,
    output x86_reg_pkg::gpr_index_e  index_reg_index,
    output logic                     sib_is_present,
    output logic                     displacement_is_present,
    output modrm_pkg::disp_len_t     displacement_length,
    output logic                     gpr_reg_used,
    output x86_reg_pkg::gpr_index_e  gpr_reg_index,
    output x86_reg_pkg::gpr_width_e  gpr_reg_bit_width
);

    // byte fields, reg in bits 5:3 is decoded elsewhere
    modrm_pkg::mod_e mod;
    logic [2:0]      rm;

    // decoder outputs ahead of the register
    logic                     ea_segment_reg_used;
    x86_reg_pkg::sreg_index_e ea_segment_reg_index;
    logic                     ea_base_reg_used;
    x86_reg_pkg::gpr_index_e  ea_base_reg_index;
    logic                     ea_index_reg_used;
    x86_reg_pkg::gpr_index_e  ea_index_reg_index;
    logic                     ea_sib_is_present;
    logic                     disp_is_present;
    modrm_pkg::disp_len_t     disp_length;
    logic                     op_gpr_reg_used;
    x86_reg_pkg::gpr_index_e  op_gpr_reg_index;
    x86_reg_pkg::gpr_width_e  op_gpr_reg_bit_width;

    assign mod = modrm_pkg::mod_e'(modrm[7:6]);
    assign rm  = modrm[2:0];

    effective_address_decode u_effective_address_decode (
        .mod                  (mod),
        .rm                   (rm),
        .default_operand_size (default_operand_size),
        .segment_reg_used     (ea_segment_reg_used),
        .segment_reg_index    (ea_segment_reg_index),
        .base_reg_used        (ea_base_reg_used),
        .base_reg_index       (ea_base_reg_index),
        .index_reg_used       (ea_index_reg_used),
        .index_reg_index      (ea_index_reg_index),
        .sib_is_present       (ea_sib_is_present)
    );

    displacement_decode u_displacement_decode (
        .mod                     (mod),
        .rm                      (rm),
        .default_operand_size    (default_operand_size),
        .displacement_is_present (disp_is_present),
        .displacement_length     (disp_length)
    );

    operand_width_decode u_operand_width_decode (
        .mod                  (mod),
        .rm                   (rm),
        .w_is_present         (w_is_present),
        .w                    (w),
        .default_operand_size (default_operand_size),
        .gpr_reg_used         (op_gpr_reg_used),
        .gpr_reg_index        (op_gpr_reg_index),
        .gpr_reg_bit_width    (op_gpr_reg_bit_width)
    );

    // single pipeline register drives every output
    decode_result_register u_decode_result_register (
        .clk                          (clk),
        .reset                        (reset),
        .in_valid                     (in_valid),
        .next_segment_reg_used        (ea_segment_reg_used),
        .next_segment_reg_index       (ea_segment_reg_index),
        .next_base_reg_used           (ea_base_reg_used),
        .next_base_reg_index          (ea_base_reg_index),
        .next_index_reg_used          (ea_index_reg_used),
        .next_index_reg_index         (ea_index_reg_index),
        .next_sib_is_present          (ea_sib_is_present),
        .next_displacement_is_present (disp_is_present),
        .next_displacement_length     (disp_length),
        .next_gpr_reg_used            (op_gpr_reg_used),
        .next_gpr_reg_index           (op_gpr_reg_index),
        .next_gpr_reg_bit_width       (op_gpr_reg_bit_width),
        .out_valid                    (out_valid),
        .segment_reg_used             (segment_reg_used),
        .segment_reg_index            (segment_reg_index),
        .base_reg_used                (base_reg_used),
        .base_reg_index               (base_reg_index),
        .index_reg_used               (index_reg_used),
        .index_reg_index              (index_reg_index),
        .sib_is_present               (sib_is_present),
        .displacement_is_present      (displacement_is_present),
        .displacement_length          (displacement_length),
        .gpr_reg_used                 (gpr_reg_used),
        .gpr_reg_index                (gpr_reg_index),
        .gpr_reg_bit_width            (gpr_reg_bit_width)
    );

endmodule

// ==== rtl/modrm_pkg.sv ====
/*
 * mod r/m byte encodings
 * mod field values, special rm codes, the default operand size and
 * the displacement length carried with each decoded byte
 */
package modrm_pkg;

    // mod field, bits 7:6 of the mod r/m byte
    typedef enum logic [1:0] {
        MOD_NO_DISP   = 2'b00,
        MOD_DISP8     = 2'b01,
        MOD_DISP_FULL = 2'b10,
        MOD_REGISTER  = 2'b11
    } mod_e;

    // default operand (and address) size of the code segment
    typedef enum logic {
        SIZE_16 = 1'b0,
        SIZE_32 = 1'b1
    } op_size_e;

    // displacement length in bytes, only 0, 1, 2 or 4 are legal
    typedef logic [2:0] disp_len_t;

    parameter disp_len_t DISP_NONE  = 3'd0;
    parameter disp_len_t DISP_BYTE  = 3'd1;
    parameter disp_len_t DISP_WORD  = 3'd2;
    parameter disp_len_t DISP_DWORD = 3'd4;

    // rm escape to an s-i-b byte in 32 bit addressing
    parameter logic [2:0] RM_SIB = 3'b100;
    // rm codes meaning "displacement only" when mod is 00
    parameter logic [2:0] RM_DISP_ONLY_16 = 3'b110;
    parameter logic [2:0] RM_DISP_ONLY_32 = 3'b101;

endpackage

// ==== rtl/operand_width_decode.sv ====
/*
 * operand width decode
 * register-direct operand selection and the general register width
 */
module operand_width_decode (
    input  modrm_pkg::mod_e         mod,
    input  logic [2:0]              rm,
    input  logic                    w_is_present,
    input  logic                    w,
    input  modrm_pkg::op_size_e     default_operand_size,
    output logic                    gpr_reg_used,
    output x86_reg_pkg::gpr_index_e gpr_reg_index,
    output x86_reg_pkg::gpr_width_e gpr_reg_bit_width
);

    // rm names a register only in mod 11
    assign gpr_reg_used  = (mod == modrm_pkg::MOD_REGISTER);
    assign gpr_reg_index = x86_reg_pkg::gpr_index_e'(rm);

    // width is computed in every mode, the reg field operand uses it too
    always_comb begin
        if (w_is_present && !w)
            gpr_reg_bit_width = x86_reg_pkg::WIDTH_8;
        else if (default_operand_size == modrm_pkg::SIZE_16)
            gpr_reg_bit_width = x86_reg_pkg::WIDTH_16;
        else
            gpr_reg_bit_width = x86_reg_pkg::WIDTH_32;
    end

    // WIDTH_NONE is only a reset value in the result register
    always_comb begin
        if (!$isunknown({w_is_present, w, default_operand_size}))
            assert final (gpr_reg_bit_width != x86_reg_pkg::WIDTH_NONE)
                else $error("operand width decoded as WIDTH_NONE");
    end

endmodule

// ==== rtl/x86_reg_pkg.sv ====
/*
 * x86 register encodings
 * general register and segment register indices as they appear in
 * instruction fields, plus the operand width of a general register
 */
package x86_reg_pkg;

    // general register codes, shared by the 8, 16 and 32 bit names
    typedef enum logic [2:0] {
        EAX = 3'd0,
        ECX = 3'd1,
        EDX = 3'd2,
        EBX = 3'd3,
        ESP = 3'd4,
        EBP = 3'd5,
        ESI = 3'd6,
        EDI = 3'd7
    } gpr_index_e;

    // 16 bit addressing names for the same codes
    parameter gpr_index_e BX = EBX;
    parameter gpr_index_e BP = EBP;
    parameter gpr_index_e SI = ESI;
    parameter gpr_index_e DI = EDI;

    // 3 bit sreg field encoding
    typedef enum logic [2:0] {
        ES = 3'd0,
        CS = 3'd1,
        SS = 3'd2,
        DS = 3'd3,
        FS = 3'd4,
        GS = 3'd5
    } sreg_index_e;

    // operand width of a general register
    typedef enum logic [1:0] {
        WIDTH_NONE = 2'd0,
        WIDTH_8    = 2'd1,
        WIDTH_16   = 2'd2,
        WIDTH_32   = 2'd3
    } gpr_width_e;

endpackage

// ==== sim/tb_modrm_decode_stage.sv ====
/*
 * testbench for the mod r/m decode stage
 * directed table of addressing forms, then a random sweep checked
 * against a rule model, one cycle latency checked on every strobe
 */
module tb_modrm_decode_stage;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TABLE_LEN    = 20;
    localparam int RANDOM_COUNT = 200;
    localparam int WATCHDOG_NS  = (TABLE_LEN + RANDOM_COUNT + 20) * 8;

    // short names for table columns
    localparam logic [2:0] SEG_SS = x86_reg_pkg::SS;
    localparam logic [2:0] SEG_DS = x86_reg_pkg::DS;
    localparam logic [2:0] R_EAX  = x86_reg_pkg::EAX;
    localparam logic [2:0] R_EBX  = x86_reg_pkg::EBX;
    localparam logic [2:0] R_EBP  = x86_reg_pkg::EBP;
    localparam logic [2:0] R_BX   = x86_reg_pkg::BX;
    localparam logic [2:0] R_BP   = x86_reg_pkg::BP;
    localparam logic [2:0] R_SI   = x86_reg_pkg::SI;
    localparam logic [2:0] R_DI   = x86_reg_pkg::DI;
    localparam logic [1:0] W8     = x86_reg_pkg::WIDTH_8;
    localparam logic [1:0] W16    = x86_reg_pkg::WIDTH_16;
    localparam logic [1:0] W32    = x86_reg_pkg::WIDTH_32;

    // every decoded field, in output port order
    typedef struct packed {
        logic       seg_used;
        logic [2:0] seg;
        logic       base_used;
        logic [2:0] base;
        logic       idx_used;
        logic [2:0] idx;
        logic       sib;
        logic       disp_present;
        logic [2:0] disp_len;
        logic       gpr_used;
        logic [2:0] gpr;
        logic [1:0] width;
    } result_t;

    logic                     clk;
    logic                     reset;
    logic                     in_valid;
    logic [7:0]               modrm;
    logic                     w_is_present;
    logic                     w;
    modrm_pkg::op_size_e      default_operand_size;
    logic                     out_valid;
    logic                     segment_reg_used;
    x86_reg_pkg::sreg_index_e segment_reg_index;
    logic                     base_reg_used;
    x86_reg_pkg::gpr_index_e  base_reg_index;
    logic                     index_reg_used;
    x86_reg_pkg::gpr_index_e  index_reg_index;
    logic                     sib_is_present;
    logic                     displacement_is_present;
    modrm_pkg::disp_len_t     displacement_length;
    logic                     gpr_reg_used;
    x86_reg_pkg::gpr_index_e  gpr_reg_index;
    x86_reg_pkg::gpr_width_e  gpr_reg_bit_width;

    // directed table
    logic [7:0] tab_modrm [TABLE_LEN];
    logic       tab_wp    [TABLE_LEN];
    logic       tab_w     [TABLE_LEN];
    logic       tab_size  [TABLE_LEN];
    result_t    tab_exp   [TABLE_LEN];
    int         tab_count = 0;

    // results in flight and the cycle each one is due
    result_t expect_q [$];
    int      due_q    [$];
    int      cycle    = 0;
    int      errors   = 0;
    int      checks   = 0;
    integer  seed     = 32'h804c_32ea;

    modrm_decode_stage dut (
        .clk(clk), .reset(reset), .in_valid(in_valid), .modrm(modrm),
        .w_is_present(w_is_present), .w(w), .default_operand_size(default_operand_size),
        .out_valid(out_valid),
        .segment_reg_used(segment_reg_used), .segment_reg_index(segment_reg_index),
        .base_reg_used(base_reg_used), .base_reg_index(base_reg_index),
        .index_reg_used(index_reg_used), .index_reg_index(index_reg_index),
        .sib_is_present(sib_is_present),
        .displacement_is_present(displacement_is_present),
        .displacement_length(displacement_length),
        .gpr_reg_used(gpr_reg_used), .gpr_reg_index(gpr_reg_index),
        .gpr_reg_bit_width(gpr_reg_bit_width)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    task automatic add_entry(input logic [7:0] byte_in, input logic wp, input logic w_bit,
                             input logic size32, input logic su, input logic [2:0] sg,
                             input logic bu, input logic [2:0] bs, input logic iu,
                             input logic [2:0] ix, input logic sb, input logic [2:0] len,
                             input logic gu, input logic [1:0] wd);
        result_t e;
        // gpr index always carries rm, presence follows the length
        e = {su, sg, bu, bs, iu, ix, sb, len != 3'd0, len, gu, byte_in[2:0], wd};
        tab_modrm[tab_count] = byte_in;
        tab_wp[tab_count]    = wp;
        tab_w[tab_count]     = w_bit;
        tab_size[tab_count]  = size32;
        tab_exp[tab_count]   = e;
        tab_count++;
    endtask

    // rule model for the random sweep
    function automatic result_t model(input logic [7:0] byte_in, input logic wp,
                                      input logic w_bit, input logic size32);
        result_t    r;
        logic [1:0] md;
        logic [2:0] rmv;
        r   = '0;
        md  = byte_in[7:6];
        rmv = byte_in[2:0];
        r.gpr      = rmv;
        r.width    = (wp && !w_bit) ? W8 : (size32 ? W32 : W16);
        r.gpr_used = (md == modrm_pkg::MOD_REGISTER);
        if (md != modrm_pkg::MOD_REGISTER && !size32) begin
            // 16 bit table, one row per rm
            case (rmv)
                3'd0: {r.base_used, r.base, r.idx_used, r.idx} = {1'b1, R_BX, 1'b1, R_SI};
                3'd1: {r.base_used, r.base, r.idx_used, r.idx} = {1'b1, R_BX, 1'b1, R_DI};
                3'd2: {r.base_used, r.base, r.idx_used, r.idx} = {1'b1, R_BP, 1'b1, R_SI};
                3'd3: {r.base_used, r.base, r.idx_used, r.idx} = {1'b1, R_BP, 1'b1, R_DI};
                3'd4: {r.idx_used, r.idx} = {1'b1, R_SI};
                3'd5: {r.idx_used, r.idx} = {1'b1, R_DI};
                3'd6: {r.base_used, r.base} = (md == 2'b00) ? 4'b0 : {1'b1, R_BP};
                default: {r.base_used, r.base} = {1'b1, R_BX};
            endcase
            r.seg_used = 1'b1;
        end else if (md != modrm_pkg::MOD_REGISTER) begin
            if (rmv == modrm_pkg::RM_SIB) begin
                r.sib = 1'b1;
            end else begin
                r.seg_used = 1'b1;
                if (!(md == 2'b00 && rmv == modrm_pkg::RM_DISP_ONLY_32))
                    {r.base_used, r.base} = {1'b1, rmv};
            end
        end
        // stack segment when the frame pointer is the base
        if (r.seg_used)
            r.seg = (r.base_used && r.base == R_BP) ? SEG_SS : SEG_DS;
        case (md)
            2'b00: r.disp_len = (!size32 && rmv == modrm_pkg::RM_DISP_ONLY_16) ? 3'd2 :
                                (size32 && rmv == modrm_pkg::RM_DISP_ONLY_32) ? 3'd4 : 3'd0;
            2'b01: r.disp_len = 3'd1;
            2'b10: r.disp_len = size32 ? 3'd4 : 3'd2;
            default: r.disp_len = 3'd0;
        endcase
        r.disp_present = (r.disp_len != 3'd0);
        return r;
    endfunction

    function automatic result_t observed();
        return {segment_reg_used, segment_reg_index, base_reg_used, base_reg_index,
                index_reg_used, index_reg_index, sib_is_present, displacement_is_present,
                displacement_length, gpr_reg_used, gpr_reg_index, gpr_reg_bit_width};
    endfunction

    task automatic check_field(input string name, input logic [2:0] got,
                               input logic [2:0] exp);
        checks++;
        assert (got === exp)
            else begin
                errors++;
                $display("ERR %0t %s: got %0d expected %0d", $time, name, got, exp);
            end
    endtask

    task automatic compare_result(input result_t exp, input result_t got);
        check_field("segment_reg_used", got.seg_used, exp.seg_used);
        check_field("segment_reg_index", got.seg, exp.seg);
        check_field("base_reg_used", got.base_used, exp.base_used);
        check_field("base_reg_index", got.base, exp.base);
        check_field("index_reg_used", got.idx_used, exp.idx_used);
        check_field("index_reg_index", got.idx, exp.idx);
        check_field("sib_is_present", got.sib, exp.sib);
        check_field("displacement_is_present", got.disp_present, exp.disp_present);
        check_field("displacement_length", got.disp_len, exp.disp_len);
        check_field("gpr_reg_used", got.gpr_used, exp.gpr_used);
        check_field("gpr_reg_index", got.gpr, exp.gpr);
        check_field("gpr_reg_bit_width", got.width, exp.width);
    endtask

    // one strobe, the result is due two counter steps later
    task automatic apply(input logic [7:0] byte_in, input logic wp, input logic w_bit,
                         input logic size32, input result_t exp);
        @(posedge clk);
        in_valid             <= 1'b1;
        modrm                <= byte_in;
        w_is_present         <= wp;
        w                    <= w_bit;
        default_operand_size <= modrm_pkg::op_size_e'(size32);
        expect_q.push_back(exp);
        due_q.push_back(cycle + 2);
    endtask

    // outputs settle between edges, sample on the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            if (due_q.size() > 0 && due_q[0] == cycle) begin
                check_field("out_valid", out_valid, 3'd1);
                compare_result(expect_q.pop_front(), observed());
                void'(due_q.pop_front());
            end else begin
                check_field("out_valid", out_valid, 3'd0);
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired at %0t before the run completed", $time);
        $display("errors: %0d of %0d checks", errors, checks);
        $display("tests failed");
        $finish;
    end

    initial begin
        logic [31:0] r;
        reset                = 1'b1;
        // strobe a decodable byte through reset, none of it may show afterwards
        in_valid             = 1'b1;
        modrm                = 8'h46;
        w_is_present         = 1'b0;
        w                    = 1'b0;
        default_operand_size = modrm_pkg::SIZE_16;

        // columns: modrm wp w size32 | seg base index sib len gpr_used width
        add_entry(8'h02, 1, 1, 0, 1, SEG_SS, 1, R_BP, 1, R_SI, 0, 0, 0, W16);
        add_entry(8'h06, 1, 1, 0, 1, SEG_DS, 0, 0, 0, 0, 0, 2, 0, W16);
        add_entry(8'h46, 1, 1, 0, 1, SEG_SS, 1, R_BP, 0, 0, 0, 1, 0, W16);
        add_entry(8'h87, 1, 1, 0, 1, SEG_DS, 1, R_BX, 0, 0, 0, 2, 0, W16);
        add_entry(8'h00, 1, 1, 0, 1, SEG_DS, 1, R_BX, 1, R_SI, 0, 0, 0, W16);
        add_entry(8'h41, 1, 1, 0, 1, SEG_DS, 1, R_BX, 1, R_DI, 0, 1, 0, W16);
        add_entry(8'h83, 1, 1, 0, 1, SEG_SS, 1, R_BP, 1, R_DI, 0, 2, 0, W16);
        add_entry(8'h04, 1, 1, 0, 1, SEG_DS, 0, 0, 1, R_SI, 0, 0, 0, W16);
        add_entry(8'h45, 1, 1, 0, 1, SEG_DS, 0, 0, 1, R_DI, 0, 1, 0, W16);
        // 32 bit addressing
        add_entry(8'h04, 1, 1, 1, 0, 0, 0, 0, 0, 0, 1, 0, 0, W32);
        add_entry(8'h84, 1, 1, 1, 0, 0, 0, 0, 0, 0, 1, 4, 0, W32);
        add_entry(8'h05, 1, 1, 1, 1, SEG_DS, 0, 0, 0, 0, 0, 4, 0, W32);
        add_entry(8'h85, 1, 1, 1, 1, SEG_SS, 1, R_EBP, 0, 0, 0, 4, 0, W32);
        add_entry(8'h43, 1, 0, 1, 1, SEG_DS, 1, R_EBX, 0, 0, 0, 1, 0, W8);
        add_entry(8'h00, 1, 1, 1, 1, SEG_DS, 1, R_EAX, 0, 0, 0, 0, 0, W32);
        add_entry(8'h44, 1, 1, 1, 0, 0, 0, 0, 0, 0, 1, 1, 0, W32);
        // register direct
        add_entry(8'hC1, 1, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 1, W8);
        add_entry(8'hC7, 1, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, W16);
        add_entry(8'hDA, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 1, W32);
        add_entry(8'hF5, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, W16);

        repeat (2) @(posedge clk);
        reset    <= 1'b0;
        in_valid <= 1'b0;
        // nothing strobed yet, everything cleared
        @(negedge clk);
        compare_result('0, observed());

        for (int i = 0; i < tab_count; i++)
            apply(tab_modrm[i], tab_wp[i], tab_w[i], tab_size[i], tab_exp[i]);
        @(posedge clk);
        in_valid <= 1'b0;
        repeat (2) @(posedge clk);

        for (int i = 0; i < RANDOM_COUNT; i++) begin
            r = $random(seed);
            apply(r[7:0], r[8], r[9], r[10], model(r[7:0], r[8], r[9], r[10]));
        end
        @(posedge clk);
        in_valid <= 1'b0;
        repeat (3) @(posedge clk);

        assert (due_q.size() == 0)
            else begin
                errors++;
                $display("%0d decoded results never appeared on the outputs", due_q.size());
            end
        $display("errors: %0d of %0d checks", errors, checks);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule
